/* verilog/mips_pkg.sv */
// Shared types for the MIPS-I instruction decode stage.
//   instr_id_e  - identity of every supported mnemonic
//   format_e    - R, I or J encoding format
//   functype_e  - function class of an instruction
//   alu_op_e    - ALU operation select
//   mem_size_e  - load/store access width
//   ctrl_t, fields_t, decoded_t - decode result bundles
package mips_pkg;

    typedef enum logic [5:0] {
        INSTR_ILLEGAL,
        INSTR_ADD, INSTR_ADDU, INSTR_SUB, INSTR_SUBU,
        INSTR_SLT, INSTR_SLTU,
        INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
        INSTR_SLL, INSTR_SRL, INSTR_SRA,
        INSTR_SLLV, INSTR_SRLV, INSTR_SRAV,
        INSTR_JR, INSTR_JALR,
        INSTR_ADDI, INSTR_ADDIU, INSTR_SLTI, INSTR_SLTIU,
        INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI,
        INSTR_BEQ, INSTR_BNE, INSTR_BLEZ, INSTR_BGTZ,
        INSTR_BLTZ, INSTR_BGEZ,
        INSTR_LW, INSTR_LH, INSTR_LHU, INSTR_LB, INSTR_LBU,
        INSTR_SW, INSTR_SH, INSTR_SB,
        INSTR_J, INSTR_JAL
    } instr_id_e;

    typedef enum logic [1:0] {
        FORMAT_R,
        FORMAT_I,
        FORMAT_J
    } format_e;

    typedef enum logic [2:0] {
        FUNC_ARITH,
        FUNC_LOGICAL,
        FUNC_SHIFT,
        FUNC_MEMLOAD,
        FUNC_MEMSTORE,
        FUNC_BRANCH,
        FUNC_JUMP
    } functype_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_LUI, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {
        MEM_WORD,
        MEM_HALF,
        MEM_BYTE
    } mem_size_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      alu_src_imm;    // Operand B from immediate.
        logic      shift_by_shamt; // Shift count from shamt, not rs.
        logic      reg_write;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      mem_unsigned;   // Zero-extend loaded data.
        logic      branch;
        logic      jump;
    } ctrl_t;

    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dest;
        logic [4:0]  shamt;
        logic [31:0] imm;
    } fields_t;

    typedef struct packed {
        instr_id_e id;
        format_e   format;
        functype_e functype;
        logic      illegal;
        ctrl_t     ctrl;
        fields_t   fields;
    } decoded_t;

endpackage

/* verilog/instr_identifier.sv */
// Instruction identifier.
// Maps the opcode, funct and rt fields of a raw instruction word
// to an instruction identity; unknown encodings give INSTR_ILLEGAL.
`timescale 1ns/1ps

module instr_identifier
    import mips_pkg::*;
(
    input  logic [31:0] instr,
    output instr_id_e   id
);

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01,
        OP_J       = 6'h02, OP_JAL    = 6'h03,
        OP_BEQ     = 6'h04, OP_BNE    = 6'h05,
        OP_BLEZ    = 6'h06, OP_BGTZ   = 6'h07,
        OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09,
        OP_SLTI    = 6'h0a, OP_SLTIU  = 6'h0b,
        OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d,
        OP_XORI    = 6'h0e, OP_LUI    = 6'h0f,
        OP_LB      = 6'h20, OP_LH     = 6'h21,
        OP_LW      = 6'h23, OP_LBU    = 6'h24,
        OP_LHU     = 6'h25, OP_SB     = 6'h28,
        OP_SH      = 6'h29, OP_SW     = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_SLL  = 6'h00, FN_SRL  = 6'h02, FN_SRA  = 6'h03,
        FN_SLLV = 6'h04, FN_SRLV = 6'h06, FN_SRAV = 6'h07,
        FN_JR   = 6'h08, FN_JALR = 6'h09,
        FN_ADD  = 6'h20, FN_ADDU = 6'h21,
        FN_SUB  = 6'h22, FN_SUBU = 6'h23,
        FN_AND  = 6'h24, FN_OR   = 6'h25,
        FN_XOR  = 6'h26, FN_NOR  = 6'h27,
        FN_SLT  = 6'h2a, FN_SLTU = 6'h2b
    } funct_e;

    opcode_e    opcode;
    funct_e     funct;
    logic [4:0] rt;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rt     = instr[20:16];

    always_comb begin
        id = INSTR_ILLEGAL;
        case (opcode)
            OP_SPECIAL: begin
                case (funct)
                    FN_SLL:  id = INSTR_SLL;
                    FN_SRL:  id = INSTR_SRL;
                    FN_SRA:  id = INSTR_SRA;
                    FN_SLLV: id = INSTR_SLLV;
                    FN_SRLV: id = INSTR_SRLV;
                    FN_SRAV: id = INSTR_SRAV;
                    FN_JR:   id = INSTR_JR;
                    FN_JALR: id = INSTR_JALR;
                    FN_ADD:  id = INSTR_ADD;
                    FN_ADDU: id = INSTR_ADDU;
                    FN_SUB:  id = INSTR_SUB;
                    FN_SUBU: id = INSTR_SUBU;
                    FN_AND:  id = INSTR_AND;
                    FN_OR:   id = INSTR_OR;
                    FN_XOR:  id = INSTR_XOR;
                    FN_NOR:  id = INSTR_NOR;
                    FN_SLT:  id = INSTR_SLT;
                    FN_SLTU: id = INSTR_SLTU;
                    default: id = INSTR_ILLEGAL;
                endcase
            end
            OP_REGIMM: begin
                case (rt)
                    5'd0:    id = INSTR_BLTZ;
                    5'd1:    id = INSTR_BGEZ;
                    default: id = INSTR_ILLEGAL; // Link and trap forms unsupported.
                endcase
            end
            OP_J:     id = INSTR_J;
            OP_JAL:   id = INSTR_JAL;
            OP_BEQ:   id = INSTR_BEQ;
            OP_BNE:   id = INSTR_BNE;
            OP_BLEZ:  id = INSTR_BLEZ;
            OP_BGTZ:  id = INSTR_BGTZ;
            OP_ADDI:  id = INSTR_ADDI;
            OP_ADDIU: id = INSTR_ADDIU;
            OP_SLTI:  id = INSTR_SLTI;
            OP_SLTIU: id = INSTR_SLTIU;
            OP_ANDI:  id = INSTR_ANDI;
            OP_ORI:   id = INSTR_ORI;
            OP_XORI:  id = INSTR_XORI;
            OP_LUI:   id = INSTR_LUI;
            OP_LB:    id = INSTR_LB;
            OP_LH:    id = INSTR_LH;
            OP_LW:    id = INSTR_LW;
            OP_LBU:   id = INSTR_LBU;
            OP_LHU:   id = INSTR_LHU;
            OP_SB:    id = INSTR_SB;
            OP_SH:    id = INSTR_SH;
            OP_SW:    id = INSTR_SW;
            default:  id = INSTR_ILLEGAL;
        endcase
    end

endmodule

/* verilog/instr_categorizer.sv */
// Instruction categorizer.
// Groups an instruction identity into its encoding format (R, I, J)
// and its function class. Unlisted identities fall back to R / arith.
`timescale 1ns/1ps

module instr_categorizer
    import mips_pkg::*;
(
    input  instr_id_e id,
    output format_e   format,
    output functype_e functype
);

    logic format_i;
    logic format_j;
    logic func_arith;
    logic func_logical;
    logic func_shift;
    logic func_memr;
    logic func_memw;
    logic func_branch;
    logic func_jump;

    assign format_j = id inside {INSTR_J, INSTR_JAL};

    assign format_i = id inside {
        INSTR_ADDI, INSTR_ADDIU, INSTR_ANDI, INSTR_ORI,
        INSTR_XORI, INSTR_LUI, INSTR_SLTI, INSTR_SLTIU,
        INSTR_BEQ, INSTR_BNE, INSTR_BGEZ, INSTR_BGTZ,
        INSTR_BLEZ, INSTR_BLTZ,
        INSTR_LW, INSTR_SW, INSTR_LB, INSTR_LBU,
        INSTR_SB, INSTR_LH, INSTR_LHU, INSTR_SH
    };

    // Sign-extended immediate group; variable shifts sit here too.
    assign func_arith = id inside {
        INSTR_ADD, INSTR_ADDU, INSTR_SUB, INSTR_SUBU,
        INSTR_SLT, INSTR_SLTU, INSTR_ADDI, INSTR_ADDIU,
        INSTR_SLTI, INSTR_SLTIU,
        INSTR_SLLV, INSTR_SRLV, INSTR_SRAV
    };

    // Zero-extended immediate group.
    assign func_logical = id inside {
        INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
        INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI
    };

    assign func_shift  = id inside {INSTR_SLL, INSTR_SRL, INSTR_SRA};
    assign func_memr   = id inside {INSTR_LW, INSTR_LB, INSTR_LBU, INSTR_LH, INSTR_LHU};
    assign func_memw   = id inside {INSTR_SW, INSTR_SB, INSTR_SH};
    assign func_branch = id inside {
        INSTR_BEQ, INSTR_BNE, INSTR_BGEZ,
        INSTR_BGTZ, INSTR_BLEZ, INSTR_BLTZ
    };
    assign func_jump   = id inside {INSTR_J, INSTR_JAL, INSTR_JALR, INSTR_JR};

    always_comb begin
        if (format_j) begin
            format = FORMAT_J;
        end else if (format_i) begin
            format = FORMAT_I;
        end else begin
            format = FORMAT_R; // Also the illegal default.
        end
    end

    always_comb begin
        if (func_arith) begin
            functype = FUNC_ARITH;
        end else if (func_logical) begin
            functype = FUNC_LOGICAL;
        end else if (func_shift) begin
            functype = FUNC_SHIFT;
        end else if (func_memr) begin
            functype = FUNC_MEMLOAD;
        end else if (func_memw) begin
            functype = FUNC_MEMSTORE;
        end else if (func_branch) begin
            functype = FUNC_BRANCH;
        end else if (func_jump) begin
            functype = FUNC_JUMP;
        end else begin
            functype = FUNC_ARITH;
        end
    end

endmodule

/* verilog/ctrl_gen.sv */
// Datapath control generator.
// Broad controls come from the function class, ALU operation,
// memory size and shift source from the instruction identity.
`timescale 1ns/1ps

module ctrl_gen
    import mips_pkg::*;
(
    input  instr_id_e id,
    input  functype_e functype,
    output ctrl_t     ctrl
);

    always_comb begin
        ctrl = '0;
        if (id != INSTR_ILLEGAL) begin
            ctrl.reg_write = functype inside {
                FUNC_ARITH, FUNC_LOGICAL, FUNC_SHIFT, FUNC_MEMLOAD
            };
            ctrl.mem_read  = (functype == FUNC_MEMLOAD);
            ctrl.mem_write = (functype == FUNC_MEMSTORE);
            ctrl.branch    = (functype == FUNC_BRANCH);
            ctrl.jump      = (functype == FUNC_JUMP);

            // Linking jumps write the return address.
            if (id inside {INSTR_JAL, INSTR_JALR}) begin
                ctrl.reg_write = 1'b1;
            end

            // I-format, excluding branches.
            ctrl.alu_src_imm = id inside {
                INSTR_ADDI, INSTR_ADDIU, INSTR_SLTI, INSTR_SLTIU,
                INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI,
                INSTR_LW, INSTR_LH, INSTR_LHU, INSTR_LB, INSTR_LBU,
                INSTR_SW, INSTR_SH, INSTR_SB
            };

            ctrl.shift_by_shamt = id inside {INSTR_SLL, INSTR_SRL, INSTR_SRA};

            case (id)
                INSTR_SUB, INSTR_SUBU,
                INSTR_BEQ, INSTR_BNE, INSTR_BLEZ,
                INSTR_BGTZ, INSTR_BLTZ, INSTR_BGEZ: ctrl.alu_op = ALU_SUB;
                INSTR_SLT, INSTR_SLTI:             ctrl.alu_op = ALU_SLT;
                INSTR_SLTU, INSTR_SLTIU:           ctrl.alu_op = ALU_SLTU;
                INSTR_AND, INSTR_ANDI:             ctrl.alu_op = ALU_AND;
                INSTR_OR, INSTR_ORI:               ctrl.alu_op = ALU_OR;
                INSTR_XOR, INSTR_XORI:             ctrl.alu_op = ALU_XOR;
                INSTR_NOR:                         ctrl.alu_op = ALU_NOR;
                INSTR_LUI:                         ctrl.alu_op = ALU_LUI;
                INSTR_SLL, INSTR_SLLV:             ctrl.alu_op = ALU_SLL;
                INSTR_SRL, INSTR_SRLV:             ctrl.alu_op = ALU_SRL;
                INSTR_SRA, INSTR_SRAV:             ctrl.alu_op = ALU_SRA;
                default:                           ctrl.alu_op = ALU_ADD; // Add, mem, jumps.
            endcase

            case (id)
                INSTR_LH, INSTR_LHU, INSTR_SH: ctrl.mem_size = MEM_HALF;
                INSTR_LB, INSTR_LBU, INSTR_SB: ctrl.mem_size = MEM_BYTE;
                default:                       ctrl.mem_size = MEM_WORD;
            endcase

            ctrl.mem_unsigned = id inside {INSTR_LHU, INSTR_LBU};
        end
    end

endmodule

/* verilog/field_extract.sv */
// Register and immediate field extraction.
// Slices rs, rt and shamt, picks the destination register and
// forms the zero- or sign-extended immediate.
`timescale 1ns/1ps

module field_extract
    import mips_pkg::*;
(
    input  logic [31:0] instr,
    input  instr_id_e   id,
    input  format_e     format,
    input  functype_e   functype,
    output fields_t     fields
);

    always_comb begin
        fields.rs    = instr[25:21];
        fields.rt    = instr[20:16];
        fields.shamt = instr[10:6];

        if (id == INSTR_JAL) begin
            fields.dest = 5'd31; // Link register.
        end else if (format == FORMAT_R) begin
            fields.dest = instr[15:11];
        end else if (format == FORMAT_I) begin
            fields.dest = instr[20:16];
        end else begin
            fields.dest = 5'd0;
        end

        if (functype == FUNC_LOGICAL) begin
            fields.imm = {16'h0000, instr[15:0]};
        end else if (format == FORMAT_J) begin
            fields.imm = {6'h00, instr[25:0]}; // Jump target index.
        end else begin
            fields.imm = {{16{instr[15]}}, instr[15:0]};
        end
    end

endmodule

/* verilog/decode_stage.sv */
// Instruction decode stage.
// Identifies, categorizes and decodes one instruction word per cycle
// and registers the decoded result with one cycle of latency.
// Holds the stage-level protocol and control assertions.
`timescale 1ns/1ps

module decode_stage
    import mips_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  logic [31:0] instr,
    output logic        out_valid,
    output decoded_t    out
);

    instr_id_e id;
    format_e   format;
    functype_e functype;
    ctrl_t     ctrl;
    fields_t   fields;
    decoded_t  decoded;

    instr_identifier u_identifier (
        .instr (instr),
        .id    (id)
    );

    instr_categorizer u_categorizer (
        .id       (id),
        .format   (format),
        .functype (functype)
    );

    ctrl_gen u_ctrl_gen (
        .id       (id),
        .functype (functype),
        .ctrl     (ctrl)
    );

    field_extract u_field_extract (
        .instr    (instr),
        .id       (id),
        .format   (format),
        .functype (functype),
        .fields   (fields)
    );

    always_comb begin
        decoded.id       = id;
        decoded.format   = format;
        decoded.functype = functype;
        decoded.illegal  = (id == INSTR_ILLEGAL);
        decoded.ctrl     = ctrl;
        decoded.fields   = fields;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                out <= decoded; // Holds while idle.
            end
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(out_valid));

    // Identifier flags illegal, control generator must stay quiet.
    a_illegal_quiet: assert property (@(posedge clk) disable iff (!rst_n)
        (out_valid && out.illegal) |->
            !(out.ctrl.reg_write || out.ctrl.mem_read || out.ctrl.mem_write ||
              out.ctrl.branch || out.ctrl.jump));

    a_mem_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(out.ctrl.mem_read && out.ctrl.mem_write));

endmodule

/* dv/decode_ref.svh */
// Reference model for the decode stage testbench.
//   decode_ref - expected decoded_t for one raw instruction word
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

function automatic decoded_t decode_ref(input logic [31:0] word);
    decoded_t   d;
    logic [5:0] op;
    logic [5:0] fn;
    op = word[31:26];
    fn = word[5:0];
    d = '0;
    d.id = INSTR_ILLEGAL;
    if (op == 6'h00) begin
        case (fn)
            6'h00: d.id = INSTR_SLL;
            6'h02: d.id = INSTR_SRL;
            6'h03: d.id = INSTR_SRA;
            6'h04: d.id = INSTR_SLLV;
            6'h06: d.id = INSTR_SRLV;
            6'h07: d.id = INSTR_SRAV;
            6'h08: d.id = INSTR_JR;
            6'h09: d.id = INSTR_JALR;
            6'h20: d.id = INSTR_ADD;
            6'h21: d.id = INSTR_ADDU;
            6'h22: d.id = INSTR_SUB;
            6'h23: d.id = INSTR_SUBU;
            6'h24: d.id = INSTR_AND;
            6'h25: d.id = INSTR_OR;
            6'h26: d.id = INSTR_XOR;
            6'h27: d.id = INSTR_NOR;
            6'h2a: d.id = INSTR_SLT;
            6'h2b: d.id = INSTR_SLTU;
            default: d.id = INSTR_ILLEGAL;
        endcase
    end else if (op == 6'h01) begin
        if (word[20:16] == 5'd0) begin
            d.id = INSTR_BLTZ;
        end else if (word[20:16] == 5'd1) begin
            d.id = INSTR_BGEZ;
        end
    end else begin
        case (op)
            6'h02: d.id = INSTR_J;
            6'h03: d.id = INSTR_JAL;
            6'h04: d.id = INSTR_BEQ;
            6'h05: d.id = INSTR_BNE;
            6'h06: d.id = INSTR_BLEZ;
            6'h07: d.id = INSTR_BGTZ;
            6'h08: d.id = INSTR_ADDI;
            6'h09: d.id = INSTR_ADDIU;
            6'h0a: d.id = INSTR_SLTI;
            6'h0b: d.id = INSTR_SLTIU;
            6'h0c: d.id = INSTR_ANDI;
            6'h0d: d.id = INSTR_ORI;
            6'h0e: d.id = INSTR_XORI;
            6'h0f: d.id = INSTR_LUI;
            6'h20: d.id = INSTR_LB;
            6'h21: d.id = INSTR_LH;
            6'h23: d.id = INSTR_LW;
            6'h24: d.id = INSTR_LBU;
            6'h25: d.id = INSTR_LHU;
            6'h28: d.id = INSTR_SB;
            6'h29: d.id = INSTR_SH;
            6'h2b: d.id = INSTR_SW;
            default: d.id = INSTR_ILLEGAL;
        endcase
    end
    d.illegal = (d.id == INSTR_ILLEGAL);

    if (d.id inside {INSTR_J, INSTR_JAL}) begin
        d.format = FORMAT_J;
    end else if (!d.illegal && op != 6'h00) begin
        d.format = FORMAT_I; // Every legal non-special opcode.
    end else begin
        d.format = FORMAT_R;
    end

    case (d.id)
        INSTR_AND, INSTR_OR, INSTR_XOR, INSTR_NOR,
        INSTR_ANDI, INSTR_ORI, INSTR_XORI, INSTR_LUI: d.functype = FUNC_LOGICAL;
        INSTR_SLL, INSTR_SRL, INSTR_SRA: d.functype = FUNC_SHIFT;
        INSTR_LW, INSTR_LH, INSTR_LHU, INSTR_LB, INSTR_LBU: d.functype = FUNC_MEMLOAD;
        INSTR_SW, INSTR_SH, INSTR_SB: d.functype = FUNC_MEMSTORE;
        INSTR_BEQ, INSTR_BNE, INSTR_BLEZ,
        INSTR_BGTZ, INSTR_BLTZ, INSTR_BGEZ: d.functype = FUNC_BRANCH;
        INSTR_J, INSTR_JAL, INSTR_JR, INSTR_JALR: d.functype = FUNC_JUMP;
        default: d.functype = FUNC_ARITH; // Variable shifts land here.
    endcase

    if (!d.illegal) begin
        d.ctrl.reg_write = d.functype inside {FUNC_ARITH, FUNC_LOGICAL, FUNC_SHIFT,
                                              FUNC_MEMLOAD} ||
                           d.id inside {INSTR_JAL, INSTR_JALR};
        d.ctrl.mem_read       = (d.functype == FUNC_MEMLOAD);
        d.ctrl.mem_write      = (d.functype == FUNC_MEMSTORE);
        d.ctrl.branch         = (d.functype == FUNC_BRANCH);
        d.ctrl.jump           = (d.functype == FUNC_JUMP);
        d.ctrl.alu_src_imm    = (d.format == FORMAT_I) && (d.functype != FUNC_BRANCH);
        d.ctrl.shift_by_shamt = (d.functype == FUNC_SHIFT);
        d.ctrl.mem_unsigned   = d.id inside {INSTR_LHU, INSTR_LBU};
        if (d.id inside {INSTR_LH, INSTR_LHU, INSTR_SH}) begin
            d.ctrl.mem_size = MEM_HALF;
        end else if (d.id inside {INSTR_LB, INSTR_LBU, INSTR_SB}) begin
            d.ctrl.mem_size = MEM_BYTE;
        end
        case (d.id)
            INSTR_SUB, INSTR_SUBU, INSTR_BEQ, INSTR_BNE,
            INSTR_BLEZ, INSTR_BGTZ, INSTR_BLTZ, INSTR_BGEZ: d.ctrl.alu_op = ALU_SUB;
            INSTR_SLT, INSTR_SLTI:   d.ctrl.alu_op = ALU_SLT;
            INSTR_SLTU, INSTR_SLTIU: d.ctrl.alu_op = ALU_SLTU;
            INSTR_AND, INSTR_ANDI:   d.ctrl.alu_op = ALU_AND;
            INSTR_OR, INSTR_ORI:     d.ctrl.alu_op = ALU_OR;
            INSTR_XOR, INSTR_XORI:   d.ctrl.alu_op = ALU_XOR;
            INSTR_NOR:               d.ctrl.alu_op = ALU_NOR;
            INSTR_LUI:               d.ctrl.alu_op = ALU_LUI;
            INSTR_SLL, INSTR_SLLV:   d.ctrl.alu_op = ALU_SLL;
            INSTR_SRL, INSTR_SRLV:   d.ctrl.alu_op = ALU_SRL;
            INSTR_SRA, INSTR_SRAV:   d.ctrl.alu_op = ALU_SRA;
            default:                 d.ctrl.alu_op = ALU_ADD;
        endcase
    end

    d.fields.rs    = word[25:21];
    d.fields.rt    = word[20:16];
    d.fields.shamt = word[10:6];
    if (d.id == INSTR_JAL) begin
        d.fields.dest = 5'd31;
    end else if (d.format == FORMAT_R) begin
        d.fields.dest = word[15:11];
    end else if (d.format == FORMAT_I) begin
        d.fields.dest = word[20:16];
    end
    if (d.functype == FUNC_LOGICAL) begin
        d.fields.imm = {16'h0000, word[15:0]};
    end else if (d.format == FORMAT_J) begin
        d.fields.imm = {6'h00, word[25:0]};
    end else begin
        d.fields.imm = {{16{word[15]}}, word[15:0]};
    end
    return d;
endfunction

`endif

/* dv/decode_tb.sv */
// Testbench for the instruction decode stage.
// Clock and reset, directed and random stimulus, a scoreboard that
// compares against decode_ref, a watchdog and the final report.
`timescale 1ns/1ps

module decode_tb
    import mips_pkg::*;
();

    `include "decode_ref.svh"

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 4;
    localparam int RANDOM_WORDS = 300;
    localparam int TOTAL_WORDS  = 42 + 6 + 30 + RANDOM_WORDS;

    // Supported funct codes under opcode 0 and supported opcodes above 1.
    localparam logic [63:0] FUNCT_USED  = 64'h0000_0CFF_0000_03DD;
    localparam logic [63:0] OPCODE_USED = 64'h0000_0B3B_0000_FFFC;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        in_valid;
    logic [31:0] instr;
    logic        out_valid;
    decoded_t    out;

    decoded_t exp_q[$];
    string    name_q[$];
    int       due_q[$];
    decoded_t exp_d;
    decoded_t last_out = '0;
    string    exp_name;
    int       due;
    int       cycle = 0;
    int       checked = 0;
    int       errors = 0;

    decode_stage dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .instr     (instr),
        .out_valid (out_valid),
        .out       (out)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic issue(input logic [31:0] word, input string name);
        @(negedge clk);
        in_valid = 1'b1;
        instr    = word;
        exp_q.push_back(decode_ref(word));
        name_q.push_back(name);
        due_q.push_back(cycle + 2); // Seen by the scoreboard two edges on.
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        in_valid = 1'b0;
        instr    = $urandom;
    endtask

    task automatic check_reset_state(input string phase);
        assert (out_valid === 1'b0) else begin
            errors++;
            $display("FAILED %s expected out_valid 0 actual %b", phase, out_valid);
        end
        assert (out === '0) else begin
            errors++;
            $display("FAILED %s expected out 0 actual %h", phase, out);
        end
    endtask

    function automatic logic [31:0] random_fields(input logic [5:0] op, input logic [5:0] fn,
                                                  input logic [4:0] rt);
        logic [31:0] w;
        w = $urandom;
        w[31:26] = op;
        if (op == 6'h00) begin
            w[5:0] = fn;
        end
        if (op == 6'h01) begin
            w[20:16] = rt;
        end
        return w;
    endfunction

    // Scoreboard.
    always @(posedge clk) begin
        cycle++;
        if (rst_n) begin
            if (out_valid) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("ERROR: out_valid high with no instruction pending");
                end
                if (exp_q.size() != 0) begin
                    exp_d    = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    due      = due_q.pop_front();
                    checked++;
                    assert (out == exp_d) else begin
                        errors++;
                        $display("FAILED %s expected %h actual %h", exp_name, exp_d, out);
                    end
                    assert (cycle == due) else begin
                        errors++;
                        $display("FAILED %s latency expected cycle %0d actual %0d",
                                 exp_name, due, cycle);
                    end
                end
            end else begin
                assert (out == last_out) else begin
                    errors++;
                    $display("FAILED hold expected %h actual %h", last_out, out);
                end
            end
            last_out = out;
        end
    end

    initial begin
        #((RESET_CYCLES + TOTAL_WORDS + 20) * CLK_PERIOD);
        $display("ERROR: watchdog expired before the tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [5:0] op;
        logic [5:0] fn;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        instr    = '0;
        void'($urandom(32'hd3f6f2a9));

        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_reset_state("reset");
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_reset_state("first edge after reset");

        // One encoding of every supported mnemonic.
        for (int f = 0; f < 64; f++) begin
            if (FUNCT_USED[f]) begin
                issue(random_fields(6'h00, 6'(f), 5'd0), $sformatf("sweep funct %02h", f));
            end
        end
        issue(random_fields(6'h01, 6'h00, 5'd0), "sweep bltz");
        issue(random_fields(6'h01, 6'h00, 5'd1), "sweep bgez");
        for (int o = 2; o < 64; o++) begin
            if (OPCODE_USED[o]) begin
                issue(random_fields(6'(o), 6'h00, 5'd0), $sformatf("sweep opcode %02h", o));
            end
        end

        issue({6'h08, 5'd3, 5'd7, 16'hff80}, "addi negative imm");
        issue({6'h23, 5'd4, 5'd9, 16'hfffc}, "lw negative offset");
        issue({6'h0d, 5'd1, 5'd2, 16'h8f0f}, "ori zero extend");
        issue({6'h0f, 5'd0, 5'd3, 16'hbeef}, "lui zero extend");
        issue({6'h02, 26'h2abcdef}, "j target");
        issue({6'h03, 26'h1234567}, "jal link dest");

        repeat (10) begin
            do begin
                op = $urandom_range(63, 2);
            end while (OPCODE_USED[op]);
            issue(random_fields(op, 6'h00, 5'd0), $sformatf("illegal opcode %02h", op));
        end
        repeat (10) begin
            do begin
                fn = $urandom_range(63, 0);
            end while (FUNCT_USED[fn]);
            issue(random_fields(6'h00, fn, 5'd0), $sformatf("illegal funct %02h", fn));
        end
        repeat (10) begin
            issue(random_fields(6'h01, 6'h00, 5'($urandom_range(31, 2))), "illegal regimm rt");
        end

        for (int i = 0; i < RANDOM_WORDS; i++) begin
            if ($urandom_range(3, 0) == 0) begin
                idle_cycle();
            end else begin
                issue($urandom, $sformatf("random word %0d", i));
            end
        end

        for (int i = 0; i < 4 && exp_q.size() != 0; i++) begin
            idle_cycle();
        end
        assert (exp_q.size() == 0) else begin
            errors++;
            $display("ERROR: %0d expected results never came out of the DUT", exp_q.size());
        end

        $display("Checked %0d results, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* all.f */
+incdir+dv
verilog/mips_pkg.sv
verilog/instr_identifier.sv
verilog/instr_categorizer.sv
verilog/ctrl_gen.sv
verilog/field_extract.sv
verilog/decode_stage.sv
dv/decode_tb.sv
